// File: memOpPkg.sv
package memOpPkg;

    // load/store opcode of the data requester
    typedef enum logic {
        opLoad,
        opStore
    } lsOp;

    // current holder of the ram port
    typedef enum logic [1:0] {
        ownNone,
        ownData,
        ownFetch
    } memOwner;

    // beat counter shared by both sequencers
    typedef enum logic [2:0] {
        stageZero,
        stageOne,
        stageTwo,
        stageThree,
        stageFour
    } beatStage;

    // wraps after stageFour
    function automatic beatStage nextStage(beatStage s);
        return (s == stageFour) ? stageZero : beatStage'(s + 3'd1);
    endfunction

endpackage

// File: memBusPkg.sv
package memBusPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int byteWidth = 8;
    localparam int lenWidth = 3;
    localparam int bytesPerWord = dataWidth / byteWidth;

    // one beat on the byte-wide ram port
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [byteWidth-1:0] wdata;
        logic                 write;
    } ramReq;

    // instruction fetch request, held until fetchDone
    typedef struct packed {
        logic                 en;
        logic [addrWidth-1:0] addr;
    } fetchReq;

    // load/store request, held until dataDone
    // len is 1, 2 or 4 bytes
    typedef struct packed {
        logic                 en;
        memOpPkg::lsOp        op;
        logic [lenWidth-1:0]  len;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } dataReq;

endpackage

// File: fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer
    import memBusPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  fetchReq              fetch,
    input  logic                 go,
    input  logic [byteWidth-1:0] ramRdata,
    output ramReq                req,
    output logic                 lastBeat,
    output logic                 fetchDone,
    output logic [dataWidth-1:0] fetchInst
);

    beatStage stage;
    logic [2:0] prevStage;
    logic [dataWidth-byteWidth-1:0] instBuf;

    assign prevStage = stage - 3'd1;

    // byte k of the word is requested in stage k
    always_comb begin
        req.addr  = fetch.addr + addrWidth'(stage);
        req.wdata = '0;
        req.write = 1'b0;
    end

    assign lastBeat = (stage == stageFour);

    // top byte comes straight from the ram in the done cycle
    assign fetchDone = go && lastBeat;
    assign fetchInst = {ramRdata, instBuf};

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= stageZero;
        end else if (go) begin
            stage <= nextStage(stage);
        end
    end

    // byte of the previous beat lands in lane stage-1
    always_ff @(posedge clk) begin
        if (go && stage != stageZero && !lastBeat) begin
            instBuf[byteWidth*prevStage[1:0] +: byteWidth] <= ramRdata;
        end
    end

    // the arbiter only steps a fetch that is still being requested
    goNeedsEn: assert property (@(posedge clk) disable iff (rst)
        go |-> fetch.en);

endmodule

// File: dataSequencer.sv
`timescale 1ns/1ps

module dataSequencer
    import memBusPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dataReq               data,
    input  logic                 go,
    input  logic [byteWidth-1:0] ramRdata,
    output ramReq                req,
    output logic                 lastBeat,
    output logic                 dataDone,
    output logic [dataWidth-1:0] dataRdata
);

    beatStage stage;
    logic isStore;
    logic [lenWidth-1:0] lenM1;
    logic [2:0] prevStage;
    logic [1:0] lane;
    logic [dataWidth-byteWidth-1:0] rdBuf;

    assign isStore   = (data.op == opStore);
    assign lenM1     = data.len - 3'd1;
    assign prevStage = stage - 3'd1;
    assign lane      = stage[1:0];

    // beat k covers byte k for both loads and stores
    always_comb begin
        req.addr  = data.addr + addrWidth'(stage);
        req.wdata = data.wdata[byteWidth*lane +: byteWidth];
        req.write = isStore;
    end

    // a store ends on its last write, a load one stage later
    // when the final byte comes back
    always_comb begin
        if (isStore) begin
            lastBeat = (stage == lenM1);
        end else begin
            lastBeat = (stage == data.len);
        end
    end

    assign dataDone = go && lastBeat;

    // zero-extended little-endian result
    // highest lane still on the ram bus
    always_comb begin
        dataRdata = '0;
        for (int k = 0; k < bytesPerWord - 1; k++) begin
            if (k < lenM1) begin
                dataRdata[byteWidth*k +: byteWidth] = rdBuf[byteWidth*k +: byteWidth];
            end
        end
        dataRdata[byteWidth*lenM1[1:0] +: byteWidth] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= stageZero;
        end else if (go) begin
            if (lastBeat) begin
                stage <= stageZero;
            end else begin
                stage <= nextStage(stage);
            end
        end
    end

    // load bytes land one stage after their address
    always_ff @(posedge clk) begin
        if (go && !isStore && stage != stageZero && !lastBeat) begin
            rdBuf[byteWidth*prevStage[1:0] +: byteWidth] <= ramRdata;
        end
    end

    lenLegal: assert property (@(posedge clk) disable iff (rst)
        data.en |-> data.len inside {3'd1, 3'd2, 3'd4});

endmodule

// File: ramArbiter.sv
`timescale 1ns/1ps

module ramArbiter
    import memBusPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  logic                 fetchEn,
    input  logic                 dataEn,
    input  ramReq                fetchReqIn,
    input  ramReq                dataReqIn,
    input  logic                 fetchLast,
    input  logic                 dataLast,
    output logic                 fetchGo,
    output logic                 dataGo,
    output memOwner              owner,
    output logic [addrWidth-1:0] ramAddr,
    output logic [byteWidth-1:0] ramWdata,
    output logic                 ramWrite
);

    memOwner ownReg;
    logic paused;
    logic selData;
    logic selFetch;
    ramReq selReq;
    logic [addrWidth-1:0] lastAddr;

    assign paused = !rdy || ioBufferFull;

    // a running transaction keeps the port, data wins when idle
    assign selData  = (ownReg == ownData) || (ownReg == ownNone && dataEn);
    assign selFetch = (ownReg == ownFetch) || (ownReg == ownNone && !dataEn && fetchEn);

    assign dataGo  = !paused && selData;
    assign fetchGo = !paused && selFetch;

    // first beat shows the new owner before the register catches up
    always_comb begin
        if (ownReg != ownNone) begin
            owner = ownReg;
        end else if (dataGo) begin
            owner = ownData;
        end else if (fetchGo) begin
            owner = ownFetch;
        end else begin
            owner = ownNone;
        end
    end

    assign selReq = selData ? dataReqIn : fetchReqIn;

    // hold the address while paused so the byte in flight stays valid
    assign ramAddr  = paused ? lastAddr : selReq.addr;
    assign ramWdata = selReq.wdata;
    assign ramWrite = dataGo && selReq.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            ownReg   <= ownNone;
            lastAddr <= '0;
        end else begin
            lastAddr <= ramAddr;
            if (dataGo) begin
                ownReg <= dataLast ? ownNone : ownData;
            end else if (fetchGo) begin
                ownReg <= fetchLast ? ownNone : ownFetch;
            end
        end
    end

    oneGo: assert property (@(posedge clk) disable iff (rst)
        !(fetchGo && dataGo));

    writeOnlyData: assert property (@(posedge clk) disable iff (rst)
        ramWrite |-> owner == ownData);

endmodule

// File: memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop
    import memBusPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  fetchReq              fetch,
    input  dataReq               data,
    input  logic [byteWidth-1:0] ramRdata,
    output logic [addrWidth-1:0] ramAddr,
    output logic [byteWidth-1:0] ramWdata,
    output logic                 ramWrite,
    output logic                 fetchDone,
    output logic [dataWidth-1:0] fetchInst,
    output logic                 dataDone,
    output logic [dataWidth-1:0] dataRdata,
    output memOwner              owner
);

    ramReq fetchRamReq;
    ramReq dataRamReq;
    logic fetchLast;
    logic dataLast;
    logic fetchGo;
    logic dataGo;

    fetchSequencer uFetchSeq (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .go        (fetchGo),
        .ramRdata  (ramRdata),
        .req       (fetchRamReq),
        .lastBeat  (fetchLast),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataSequencer uDataSeq (
        .clk       (clk),
        .rst       (rst),
        .data      (data),
        .go        (dataGo),
        .ramRdata  (ramRdata),
        .req       (dataRamReq),
        .lastBeat  (dataLast),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    ramArbiter uArbiter (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetch.en),
        .dataEn       (data.en),
        .fetchReqIn   (fetchRamReq),
        .dataReqIn    (dataRamReq),
        .fetchLast    (fetchLast),
        .dataLast     (dataLast),
        .fetchGo      (fetchGo),
        .dataGo       (dataGo),
        .owner        (owner),
        .ramAddr      (ramAddr),
        .ramWdata     (ramWdata),
        .ramWrite     (ramWrite)
    );

endmodule

// File: memCtrlChecker.sv
`timescale 1ns/1ps

module memCtrlChecker
    import memBusPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  fetchReq              fetch,
    input  dataReq               data,
    input  logic [addrWidth-1:0] ramAddr,
    input  logic [byteWidth-1:0] ramWdata,
    input  logic                 ramWrite,
    input  logic                 fetchDone,
    input  logic [dataWidth-1:0] fetchInst,
    input  logic                 dataDone,
    input  logic [dataWidth-1:0] dataRdata,
    input  memOwner              owner,
    output int                   errorCount
);

    logic [byteWidth-1:0] shadow [256];
    logic [31:0] fillState;
    logic [addrWidth-1:0] offset;
    logic [dataWidth-1:0] expWord;
    int writeCount;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // zero-extended little-endian word from the shadow
    function automatic logic [dataWidth-1:0] shadowWord(logic [addrWidth-1:0] addr, int len);
        logic [dataWidth-1:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[byteWidth*k +: byteWidth] = shadow[8'(addr + 32'(k))];
        end
        return w;
    endfunction

    // same fill sequence as the ram model
    initial begin
        errorCount = 0;
        writeCount = 0;
        fillState = 32'haf09_ae63;
        for (int i = 0; i < 256; i++) begin
            fillState = xorshift32(fillState);
            shadow[i] = fillState[7:0];
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            writeCount = 0;
        end else begin
            if (!rdy || ioBufferFull) begin
                if (ramWrite || fetchDone || dataDone) begin
                    $display("write or done pulse seen in a paused cycle");
                    errorCount++;
                end
            end
            if (!fetch.en && !data.en && owner != ownNone) begin
                $display("** Error: owner got %h expected %h", owner, ownNone);
                errorCount++;
            end
            if (fetchDone) begin
                expWord = shadowWord(fetch.addr, 4);
                if (fetchInst !== expWord) begin
                    $display("** Error: fetchInst got %h expected %h", fetchInst, expWord);
                    errorCount++;
                end
            end
            if (dataDone && data.op == opLoad) begin
                expWord = shadowWord(data.addr, int'(data.len));
                if (dataRdata !== expWord) begin
                    $display("** Error: dataRdata got %h expected %h", dataRdata, expWord);
                    errorCount++;
                end
            end
            if (ramWrite) begin
                offset = ramAddr - data.addr;
                if (!data.en || data.op != opStore) begin
                    $display("ram write seen with no store in progress");
                    errorCount++;
                end else if (offset != 32'(writeCount) || offset >= 32'(data.len)) begin
                    $display("** Error: ramAddr got %h expected %h",
                             ramAddr, data.addr + 32'(writeCount));
                    errorCount++;
                end else if (ramWdata !== data.wdata[byteWidth*offset[1:0] +: byteWidth]) begin
                    $display("** Error: ramWdata got %h expected %h",
                             ramWdata, data.wdata[byteWidth*offset[1:0] +: byteWidth]);
                    errorCount++;
                end
                shadow[ramAddr[7:0]] = ramWdata;
                writeCount++;
            end
            if (dataDone && data.op == opStore) begin
                if (writeCount != int'(data.len)) begin
                    $display("** Error: store writeCount got %h expected %h",
                             writeCount, data.len);
                    errorCount++;
                end
                writeCount = 0;
            end
        end
    end

endmodule

// File: memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb
    import memBusPkg::*;
    import memOpPkg::*;
();

    localparam int rowCount = 17;
    localparam int waitLimit = 64;

    // one request set; expCycles is the cycle of the last done when unpaused
    typedef struct packed {
        logic                 fetchEn;
        logic [addrWidth-1:0] fetchAddr;
        logic                 dataEn;
        lsOp                  op;
        logic [lenWidth-1:0]  len;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 paused;
        int                   expCycles;
    } stimRow;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    fetchReq fetch;
    dataReq data;
    logic [byteWidth-1:0] ramRdata = '0;
    logic [addrWidth-1:0] ramAddr;
    logic [byteWidth-1:0] ramWdata;
    logic ramWrite;
    logic fetchDone;
    logic [dataWidth-1:0] fetchInst;
    logic dataDone;
    logic [dataWidth-1:0] dataRdata;
    memOwner owner;

    logic [byteWidth-1:0] mem [256];
    logic [31:0] randState;
    stimRow rows [rowCount];
    int tbErrors;
    int checkErrors;
    logic timedOut;

    always #2 clk = ~clk;

    memCtrlTop i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetch        (fetch),
        .data         (data),
        .ramRdata     (ramRdata),
        .ramAddr      (ramAddr),
        .ramWdata     (ramWdata),
        .ramWrite     (ramWrite),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner)
    );

    memCtrlChecker uChecker (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetch        (fetch),
        .data         (data),
        .ramAddr      (ramAddr),
        .ramWdata     (ramWdata),
        .ramWrite     (ramWrite),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner),
        .errorCount   (checkErrors)
    );

    // byte ram, one cycle read latency
    always @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr[7:0]] <= ramWdata;
        end
        ramRdata <= mem[ramAddr[7:0]];
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drivePause(input logic randomPause);
        if (randomPause) begin
            randState = xorshift32(randState);
            rdy = randState[0] | randState[1];
            ioBufferFull = randState[2] & randState[3];
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
    endtask

    task automatic fillRows();
        rows[0]  = '{1'b1, 32'h10, 1'b0, opLoad,  3'd1, 32'h00, 32'h0000_0000, 1'b0, 4};
        rows[1]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd1, 32'h21, 32'h0000_0000, 1'b0, 1};
        rows[2]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd2, 32'h32, 32'h0000_0000, 1'b0, 2};
        rows[3]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd4, 32'h40, 32'h0000_0000, 1'b0, 4};
        rows[4]  = '{1'b0, 32'h00, 1'b1, opStore, 3'd1, 32'h50, 32'h0000_00a5, 1'b0, 0};
        rows[5]  = '{1'b0, 32'h00, 1'b1, opStore, 3'd2, 32'h60, 32'h0000_beef, 1'b0, 1};
        rows[6]  = '{1'b0, 32'h00, 1'b1, opStore, 3'd4, 32'h70, 32'hdead_c0de, 1'b0, 3};
        rows[7]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd4, 32'h70, 32'h0000_0000, 1'b0, 4};
        rows[8]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd2, 32'h60, 32'h0000_0000, 1'b0, 2};
        rows[9]  = '{1'b0, 32'h00, 1'b1, opLoad,  3'd1, 32'h50, 32'h0000_0000, 1'b0, 1};
        // data wins when both sides ask at once
        rows[10] = '{1'b1, 32'h70, 1'b1, opStore, 3'd4, 32'h80, 32'h1234_5678, 1'b0, 8};
        rows[11] = '{1'b1, 32'h80, 1'b1, opLoad,  3'd2, 32'h90, 32'h0000_0000, 1'b0, 7};
        rows[12] = '{1'b1, 32'h84, 1'b0, opLoad,  3'd1, 32'h00, 32'h0000_0000, 1'b1, 0};
        rows[13] = '{1'b0, 32'h00, 1'b1, opStore, 3'd4, 32'ha0, 32'hcafe_f00d, 1'b1, 0};
        rows[14] = '{1'b0, 32'h00, 1'b1, opLoad,  3'd4, 32'ha0, 32'h0000_0000, 1'b1, 0};
        rows[15] = '{1'b1, 32'ha0, 1'b1, opLoad,  3'd1, 32'ha2, 32'h0000_0000, 1'b1, 0};
        rows[16] = '{1'b0, 32'h00, 1'b1, opLoad,  3'd2, 32'h11, 32'h0000_0000, 1'b1, 0};
    endtask

    task automatic runRow(input stimRow row, input int idx);
        logic fetchPending;
        logic dataPending;
        logic both;
        logic sawDataOwner;
        logic sawFetchOwner;
        int cycle;
        int fetchAt;
        int dataAt;
        int lastAt;
        fetchPending = row.fetchEn;
        dataPending = row.dataEn;
        both = row.fetchEn && row.dataEn;
        sawDataOwner = 1'b0;
        sawFetchOwner = 1'b0;
        cycle = 0;
        fetchAt = -1;
        dataAt = -1;
        fetch = '{row.fetchEn, row.fetchAddr};
        data = '{row.dataEn, row.op, row.len, row.addr, row.wdata};
        drivePause(row.paused);
        while (fetchPending || dataPending) begin
            @(negedge clk);
            if (both) begin
                if ((owner == ownFetch && dataPending) || (owner == ownData && !dataPending)) begin
                    $display("row %0d: port owner out of order for a concurrent request", idx);
                    tbErrors++;
                end
                sawDataOwner = sawDataOwner || (owner == ownData);
                sawFetchOwner = sawFetchOwner || (owner == ownFetch);
            end
            if (fetchDone) begin
                fetchPending = 1'b0;
                fetchAt = cycle;
            end
            if (dataDone) begin
                dataPending = 1'b0;
                dataAt = cycle;
            end
            @(posedge clk);
            #1;
            if (!fetchPending) begin
                fetch.en = 1'b0;
            end
            if (!dataPending) begin
                data.en = 1'b0;
            end
            drivePause(row.paused);
            if (fetchPending || dataPending) begin
                cycle++;
                if (cycle > waitLimit) begin
                    $display("row %0d: no done pulse within %0d cycles", idx, waitLimit);
                    timedOut = 1'b1;
                    return;
                end
            end
        end
        if (both && (dataAt >= fetchAt || !sawDataOwner || !sawFetchOwner)) begin
            $display("row %0d: data request was not served before the fetch", idx);
            tbErrors++;
        end
        if (!row.paused) begin
            lastAt = (fetchAt > dataAt) ? fetchAt : dataAt;
            if (lastAt != row.expCycles) begin
                $display("** Error: row %0d done cycle got %h expected %h",
                         idx, lastAt, row.expCycles);
                tbErrors++;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetch = '0;
        data = '0;
        tbErrors = 0;
        timedOut = 1'b0;
        randState = 32'haf09_ae63;
        for (int i = 0; i < 256; i++) begin
            randState = xorshift32(randState);
            mem[i] = randState[7:0];
        end
        fillRows();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < rowCount && !timedOut; r++) begin
            runRow(rows[r], r);
            // idle cycle with both requests low, port must be released
            @(posedge clk);
            #1;
        end
        $display("errors: checker %0d, testbench %0d, timeouts %0d",
                 checkErrors, tbErrors, timedOut);
        if (checkErrors == 0 && tbErrors == 0 && !timedOut) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: src.f
memOpPkg.sv
memBusPkg.sv
fetchSequencer.sv
dataSequencer.sv
ramArbiter.sv
memCtrlTop.sv
memCtrlChecker.sv
memCtrlTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memCtrlTb -f src.f -o memCtrlSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/memCtrlSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
